// File: fm.f
hw/fm_pkg.sv
hw/fm_clock_seq.sv
hw/fm_mmr.sv
hw/fm_timers.sv
hw/fm_phase_gen.sv
hw/fm_mixer.sv
hw/fm_top.sv
bench/fm_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the FM core simulation, the exit status gives pass or fail
cd "$(dirname "$0")" \
    && verilator --binary --assert --top-module fm_tb -f fm.f -o fm_sim \
    && ./obj_dir/fm_sim \
    || exit 1

// File: bench/fm_tb.sv
// FM core testbench
`timescale 1ns/1ps

module fm_tb;

    localparam int NUM_CH     = 6;
    localparam int MAX_CYCLES = 100000;   // About 450 samples of 144 clk each, plus margin

    logic         clk;
    logic         rst_n;
    logic [7:0]   din;
    logic [1:0]   addr;
    logic         cs_n;
    logic         wr_n;
    logic [7:0]   dout;
    logic         irq_n;
    fm_pkg::snd_t snd_left;
    fm_pkg::snd_t snd_right;
    logic         snd_sample;

    // Reference model of the channel state
    int fnums  [NUM_CH];
    int blocks [NUM_CH];
    int phases [NUM_CH];
    bit pan_l  [NUM_CH];
    bit pan_r  [NUM_CH];
    int seed;
    int cycles = 0;

    fm_top #(.NUM_CH(NUM_CH), .CEN_DIV(6)) UUT (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .din        ( din        ),
        .addr       ( addr       ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .dout       ( dout       ),
        .irq_n      ( irq_n      ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Errors found");
            $fatal(1, "Simulation timed out after %0d cycles", MAX_CYCLES);
        end
    end

    task automatic report_error();
        $display("Errors found");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    task automatic check_eq(input int got, input int exp, input string what);
        assert (got == exp) else begin
            $display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
            report_error();
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fffffff;
        return lo + r % (hi - lo + 1);
    endfunction

    // Signed sawtooth from the phase MSBs
    function automatic int voice_of(input int ph);
        int v;
        v = (ph >> (fm_pkg::PHASE_W - fm_pkg::VOICE_W)) & ((1 << fm_pkg::VOICE_W) - 1);
        if (v >= (1 << (fm_pkg::VOICE_W - 1))) v = v - (1 << fm_pkg::VOICE_W);
        return v;
    endfunction

    // Address cycle, then data cycle
    task automatic write_reg(input logic bank, input logic [7:0] num, input logic [7:0] data);
        @(posedge clk);
        #1;
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = {bank, 1'b0};
        din  = num;
        @(posedge clk);
        #1;
        addr = {bank, 1'b1};
        din  = data;
        @(posedge clk);
        #1;
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    // Waits for the strobe, checks the stereo pair, then steps the model phases
    task automatic next_sample();
        int exp_l;
        int exp_r;
        exp_l = 0;
        exp_r = 0;
        @(negedge clk);
        while (!snd_sample) @(negedge clk);
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (pan_l[ch]) exp_l += voice_of(phases[ch]);
            if (pan_r[ch]) exp_r += voice_of(phases[ch]);
        end
        check_eq(int'(snd_left), exp_l, "snd_left");
        check_eq(int'(snd_right), exp_r, "snd_right");
        check_eq(int'(dout[7]), 0, "busy at sample");
        for (int ch = 0; ch < NUM_CH; ch++) begin
            phases[ch] = (phases[ch] + ((fnums[ch] << blocks[ch]) >> 1))
                         & ((1 << fm_pkg::PHASE_W) - 1);
        end
    endtask

    task automatic set_channel(input int ch, input int fn, input int blk, input int pn);
        logic       bank;
        logic [7:0] sub;
        bank = (ch >= 3);
        sub  = 8'(ch % 3);
        write_reg(bank, 8'(fm_pkg::FNUM_HI) + sub, {2'b00, blk[2:0], fn[10:8]});
        check_eq(int'(dout[7]), 1, "busy after write");
        write_reg(bank, 8'(fm_pkg::FNUM_LO) + sub, fn[7:0]);
        write_reg(bank, 8'(fm_pkg::PAN) + sub, {pn[1:0], 6'd0});
        fnums[ch]  = fn;
        blocks[ch] = blk;
        pan_l[ch]  = pn[1];
        pan_r[ch]  = pn[0];
    endtask

    initial begin
        int va;
        int vb;
        int n;
        seed  = 32'h6b9313a0;
        rst_n = 1'b0;
        din   = '0;
        addr  = '0;
        cs_n  = 1'b1;
        wr_n  = 1'b1;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            fnums[ch]  = 0;
            blocks[ch] = 0;
            phases[ch] = 0;
            pan_l[ch]  = 1'b1;
            pan_r[ch]  = 1'b1;
        end
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_eq(int'(dout), 0, "dout after reset");
        check_eq(int'(irq_n), 1, "irq_n after reset");

        // Random frequencies and panning, up to two channels per sample
        for (int i = 0; i < 300; i++) begin
            next_sample();
            repeat (rand_range(0, 2)) begin
                set_channel(rand_range(0, NUM_CH - 1), rand_range(0, 2047),
                            rand_range(0, 7), rand_range(0, 3));
            end
        end

        // Timer A with its irq enabled
        next_sample();
        va = rand_range(1010, 1020);
        n  = 1024 - va;
        write_reg(1'b0, 8'(fm_pkg::TIMER_A_HI), va[9:2]);
        write_reg(1'b0, 8'(fm_pkg::TIMER_A_LO), {6'd0, va[1:0]});
        write_reg(1'b0, 8'(fm_pkg::TIMER_CTL), 8'h05);
        for (int j = 1; j <= n + 1; j++) begin
            next_sample();
            if (j <= n - 1) check_eq(int'(dout[0]), 0, "flag_a before overflow");
        end
        check_eq(int'(dout[0]), 1, "flag_a after overflow");
        check_eq(int'(irq_n), 0, "irq_n on flag_a");
        write_reg(1'b0, 8'(fm_pkg::TIMER_CTL), 8'h10);
        next_sample();
        check_eq(int'(dout[0]), 0, "flag_a after clear");
        check_eq(int'(irq_n), 1, "irq_n after clear");

        // Timer B, first with its irq on, then off
        vb = rand_range(252, 254);
        n  = 256 - vb;
        write_reg(1'b0, 8'(fm_pkg::TIMER_B), 8'(vb));
        write_reg(1'b0, 8'(fm_pkg::TIMER_CTL), 8'h0A);
        for (int j = 1; j <= n * 16 + 1; j++) begin
            next_sample();
            if (j <= (n - 1) * 16) check_eq(int'(dout[1]), 0, "flag_b before overflow");
        end
        check_eq(int'(dout[1]), 1, "flag_b after overflow");
        check_eq(int'(irq_n), 0, "irq_n on flag_b");
        write_reg(1'b0, 8'(fm_pkg::TIMER_CTL), 8'h22);
        for (int j = 1; j <= n * 16 + 1; j++) begin
            next_sample();
            check_eq(int'(dout[1]), 0, "flag_b with irq off");
            check_eq(int'(irq_n), 1, "irq_n with irq off");
        end

        $display("No errors");
        $finish;
    end

endmodule

// File: hw/fm_top.sv
// FM sound core top level
`timescale 1ns/1ps

module fm_top #(
    parameter int NUM_CH  = 6,
    parameter int CEN_DIV = 6
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [7:0]   din,
    input  logic [1:0]   addr,
    input  logic         cs_n,
    input  logic         wr_n,
    output logic [7:0]   dout,
    output logic         irq_n,
    output fm_pkg::snd_t snd_left,
    output fm_pkg::snd_t snd_right,
    output logic         snd_sample
);

    logic                clk_en;
    logic                zero;     // One pulse per sample frame
    // Timer control
    logic [9:0]          value_a;
    logic [7:0]          value_b;
    logic                load_a;
    logic                load_b;
    logic                irq_en_a;
    logic                irq_en_b;
    logic                clr_a;
    logic                clr_b;
    logic                flag_a;
    logic                flag_b;
    // Channel frequency and panning
    fm_pkg::fnum_t       freq_fnum;
    fm_pkg::block_t      freq_block;
    logic [NUM_CH-1:0]   freq_wr;
    logic [2*NUM_CH-1:0] pan;
    fm_pkg::voice_t      voices [NUM_CH];

    fm_clock_seq #(.CEN_DIV(CEN_DIV)) u_seq (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .clk_en ( clk_en ),
        .zero   ( zero   )
    );

    fm_mmr #(.NUM_CH(NUM_CH)) u_mmr (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .clk_en     ( clk_en     ),
        .din        ( din        ),
        .addr       ( addr       ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .flag_a     ( flag_a     ),
        .flag_b     ( flag_b     ),
        .dout       ( dout       ),
        .value_a    ( value_a    ),
        .value_b    ( value_b    ),
        .load_a     ( load_a     ),
        .load_b     ( load_b     ),
        .irq_en_a   ( irq_en_a   ),
        .irq_en_b   ( irq_en_b   ),
        .clr_a      ( clr_a      ),
        .clr_b      ( clr_b      ),
        .freq_fnum  ( freq_fnum  ),
        .freq_block ( freq_block ),
        .freq_wr    ( freq_wr    ),
        .pan        ( pan        )
    );

    fm_timers u_timers (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .zero     ( zero     ),
        .value_a  ( value_a  ),
        .value_b  ( value_b  ),
        .load_a   ( load_a   ),
        .load_b   ( load_b   ),
        .irq_en_a ( irq_en_a ),
        .irq_en_b ( irq_en_b ),
        .clr_a    ( clr_a    ),
        .clr_b    ( clr_b    ),
        .flag_a   ( flag_a   ),
        .flag_b   ( flag_b   ),
        .irq_n    ( irq_n    )
    );

    for (genvar ch = 0; ch < NUM_CH; ch++) begin : gen_ch
        fm_phase_gen u_pg (
            .clk        ( clk         ),
            .rst_n      ( rst_n       ),
            .zero       ( zero        ),
            .freq_wr    ( freq_wr[ch] ),
            .freq_fnum  ( freq_fnum   ),
            .freq_block ( freq_block  ),
            .voice      ( voices[ch]  )
        );
    end

    fm_mixer #(.NUM_CH(NUM_CH)) u_mixer (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .zero       ( zero       ),
        .voices     ( voices     ),
        .pan        ( pan        ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

endmodule

// File: hw/fm_mixer.sv
// Stereo mixer
`timescale 1ns/1ps

module fm_mixer #(
    parameter int NUM_CH = 6
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                zero,
    input  fm_pkg::voice_t      voices [NUM_CH],
    input  logic [2*NUM_CH-1:0] pan,           // Left in the odd bit
    output fm_pkg::snd_t        snd_left,
    output fm_pkg::snd_t        snd_right,
    output logic                snd_sample
);

    fm_pkg::snd_t sum_l;
    fm_pkg::snd_t sum_r;
    fm_pkg::snd_t acc_l;
    fm_pkg::snd_t acc_r;
    logic         zero_d;

    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (pan[2*ch+1]) sum_l = sum_l + fm_pkg::snd_t'(voices[ch]);
            if (pan[2*ch])   sum_r = sum_r + fm_pkg::snd_t'(voices[ch]);
        end
    end

    // Captures the voices before this frame's phase step
    always_ff @(posedge clk) begin
        if (zero) begin
            acc_l <= sum_l;
            acc_r <= sum_r;
        end
        if (zero_d) begin
            snd_left  <= acc_l;
            snd_right <= acc_r;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            zero_d     <= 1'b0;
            snd_sample <= 1'b0;
        end else begin
            zero_d     <= zero;
            snd_sample <= zero_d;   // High with the new output pair
        end
    end

    a_sample_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        snd_sample |=> !snd_sample);

endmodule

// File: hw/fm_phase_gen.sv
// Channel phase generator
`timescale 1ns/1ps

module fm_phase_gen (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           zero,
    input  logic           freq_wr,
    input  fm_pkg::fnum_t  freq_fnum,
    input  fm_pkg::block_t freq_block,
    output fm_pkg::voice_t voice
);

    fm_pkg::fnum_t  fnum;
    fm_pkg::block_t block;
    fm_pkg::phase_t phase;
    fm_pkg::phase_t inc;

    // Frequency word for this channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fnum  <= '0;
            block <= '0;
        end else if (freq_wr) begin
            fnum  <= freq_fnum;
            block <= freq_block;
        end
    end

    // Octave shift, then halved
    assign inc = (fm_pkg::phase_t'(fnum) << block) >> 1;

    // One step per sample frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (zero) begin
            phase <= phase + inc;   // Wraps at PHASE_W bits
        end
    end

    // Sawtooth from the top bits
    assign voice = fm_pkg::voice_t'(phase[fm_pkg::PHASE_W-1 -: fm_pkg::VOICE_W]);

endmodule

// File: hw/fm_timers.sv
// Timer A and timer B
`timescale 1ns/1ps

module fm_timers (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       zero,
    input  logic [9:0] value_a,
    input  logic [7:0] value_b,
    input  logic       load_a,
    input  logic       load_b,
    input  logic       irq_en_a,
    input  logic       irq_en_b,
    input  logic       clr_a,
    input  logic       clr_b,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq_n
);

    localparam int PRE_W = $clog2(fm_pkg::TMRB_PRESCALE);

    logic [10:0]      cnt_a;      // Counts left before overflow
    logic [8:0]       cnt_b;
    logic [10:0]      reload_a;
    logic [8:0]       reload_b;
    logic [PRE_W-1:0] pre_b;
    logic             tick_b;
    logic             ovf_a;
    logic             ovf_b;

    assign reload_a = 11'd1024 - {1'b0, value_a};
    assign reload_b = 9'd256 - {1'b0, value_b};

    // Prescaler is never stopped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_b <= '0;
        end else if (zero) begin
            pre_b <= pre_b + 1'b1;
        end
    end

    assign tick_b = zero && (pre_b == PRE_W'(fm_pkg::TMRB_PRESCALE - 1));
    assign ovf_a  = zero && load_a && (cnt_a == 11'd1);
    assign ovf_b  = tick_b && load_b && (cnt_b == 9'd1);

    // Held at the reload value while stopped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_a <= 11'd1024;
            cnt_b <= 9'd256;
        end else begin
            if (!load_a || ovf_a) begin
                cnt_a <= reload_a;
            end else if (zero) begin
                cnt_a <= cnt_a - 1'b1;
            end
            if (!load_b || ovf_b) begin
                cnt_b <= reload_b;
            end else if (tick_b) begin
                cnt_b <= cnt_b - 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (clr_a) flag_a <= 1'b0;
            else if (ovf_a && irq_en_a) flag_a <= 1'b1;
            if (clr_b) flag_b <= 1'b0;
            else if (ovf_b && irq_en_b) flag_b <= 1'b1;
        end
    end

    assign irq_n = !(flag_a || flag_b);

    // Flag B needs a running timer with its irq enabled
    a_flag_b_src: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(flag_b) |-> $past(load_b && irq_en_b));

    // Flag A only comes from a running, enabled timer
    a_flag_a_src: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(flag_a) |-> $past(load_a && irq_en_a));

endmodule

// File: hw/fm_mmr.sv
// Register file and bus decoder
`timescale 1ns/1ps

module fm_mmr #(
    parameter int NUM_CH = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clk_en,
    input  logic [7:0]            din,
    input  logic [1:0]            addr,
    input  logic                  cs_n,
    input  logic                  wr_n,
    input  logic                  flag_a,
    input  logic                  flag_b,
    output logic [7:0]            dout,
    output logic [9:0]            value_a,
    output logic [7:0]            value_b,
    output logic                  load_a,
    output logic                  load_b,
    output logic                  irq_en_a,
    output logic                  irq_en_b,
    output logic                  clr_a,
    output logic                  clr_b,
    output fm_pkg::fnum_t         freq_fnum,
    output fm_pkg::block_t        freq_block,
    output logic [NUM_CH-1:0]     freq_wr,
    output logic [2*NUM_CH-1:0]   pan
);

    localparam int BUSY_W = $clog2(fm_pkg::BUSY_TICKS + 1);

    logic              write;
    logic              addr_wr;
    logic              data_wr;
    logic              bank;
    logic [7:0]        sel_reg [2];   // Register number per bank
    logic [7:0]        cur_num;
    logic [1:0]        sub;
    logic [2:0]        ch_idx;
    logic              ch_ok;
    fm_pkg::reg_addr_e reg_num;
    logic [5:0]        hi_latch [2];  // Block and fnum MSBs waiting for the low byte
    logic [BUSY_W-1:0] busy_cnt;
    logic              busy;

    assign write   = !cs_n && !wr_n;
    assign addr_wr = write && !addr[0];
    assign data_wr = write && addr[0];
    assign bank    = addr[1];
    assign cur_num = sel_reg[bank];
    assign sub     = cur_num[1:0];

    // Fold the channel bits out of the A0 and above range before decoding
    assign reg_num = fm_pkg::reg_addr_e'((cur_num >= 8'hA0) ? {cur_num[7:2], 2'b00} : cur_num);

    // Bank 1 holds channels 3 to 5
    assign ch_idx = bank ? 3'd3 + {1'b0, sub} : {1'b0, sub};
    assign ch_ok  = (sub != 2'd3) && (int'(ch_idx) < NUM_CH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_reg[0]  <= '0;
            sel_reg[1]  <= '0;
            hi_latch[0] <= '0;
            hi_latch[1] <= '0;
            value_a     <= '0;
            value_b     <= '0;
            load_a      <= 1'b0;
            load_b      <= 1'b0;
            irq_en_a    <= 1'b0;
            irq_en_b    <= 1'b0;
            clr_a       <= 1'b0;
            clr_b       <= 1'b0;
            freq_wr     <= '0;
            pan         <= '1;     // Both sides on
        end else begin
            freq_wr <= '0;         // Strobes last one cycle
            clr_a   <= 1'b0;
            clr_b   <= 1'b0;
            if (addr_wr) begin
                sel_reg[bank] <= din;
            end
            if (data_wr) begin
                case (reg_num)
                    fm_pkg::TIMER_A_HI: value_a[9:2] <= din;
                    fm_pkg::TIMER_A_LO: value_a[1:0] <= din[1:0];
                    fm_pkg::TIMER_B:    value_b      <= din;
                    fm_pkg::TIMER_CTL: begin
                        load_a   <= din[0];
                        load_b   <= din[1];
                        irq_en_a <= din[2];
                        irq_en_b <= din[3];
                        clr_a    <= din[4];
                        clr_b    <= din[5];
                    end
                    fm_pkg::FNUM_HI: hi_latch[bank] <= din[5:0];
                    fm_pkg::FNUM_LO: begin
                        if (ch_ok) begin
                            freq_wr[ch_idx] <= 1'b1;
                        end
                    end
                    fm_pkg::PAN: begin
                        if (ch_ok) begin
                            pan[2*ch_idx +: 2] <= din[7:6];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Low byte write sends the whole frequency word out with freq_wr
    always_ff @(posedge clk) begin
        if (data_wr && reg_num == fm_pkg::FNUM_LO) begin
            freq_fnum  <= {hi_latch[bank][2:0], din};
            freq_block <= hi_latch[bank][5:3];
        end
    end

    // Busy counts down in clock enables, a new write restarts it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= BUSY_W'(fm_pkg::BUSY_TICKS);
        end else if (clk_en && busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = (busy_cnt != '0);
    assign dout = {busy, 5'd0, flag_b, flag_a};

    a_one_freq_wr: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(freq_wr));

    // Last enable of the busy window must release it
    a_busy_ends: assert property (@(posedge clk) disable iff (!rst_n)
        clk_en && busy_cnt == BUSY_W'(1) && !data_wr |=> !busy);

endmodule

// File: hw/fm_clock_seq.sv
// Clock enable and slot sequencer
`timescale 1ns/1ps

module fm_clock_seq #(
    parameter int CEN_DIV = 6
) (
    input  logic clk,
    input  logic rst_n,
    output logic clk_en,
    output logic zero
);

    localparam int DIV_W  = ($clog2(CEN_DIV) > 0) ? $clog2(CEN_DIV) : 1;
    localparam int SLOT_W = $clog2(fm_pkg::SLOTS);

    logic [DIV_W-1:0]  div_cnt;
    logic [SLOT_W-1:0] slot;
    logic              slot_last;

    // Free running divider with clk_en on its last count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (clk_en) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign clk_en = (div_cnt == DIV_W'(CEN_DIV - 1));

    // One step per operator slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (clk_en) begin
            slot <= slot_last ? '0 : slot + 1'b1;
        end
    end

    assign slot_last = (slot == SLOT_W'(fm_pkg::SLOTS - 1));
    assign zero      = clk_en && slot_last;   // Start of a new sample frame

    // Slot count restarts with each frame
    a_slot_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        zero |=> (slot == '0));

endmodule

// File: hw/fm_pkg.sv
// FM core shared definitions
package fm_pkg;

    // Frame and datapath widths
    localparam int SLOTS   = 24;   // Operator slots per output sample
    localparam int FNUM_W  = 11;
    localparam int BLOCK_W = 3;
    localparam int PHASE_W = 20;
    localparam int VOICE_W = 10;   // Signed sawtooth taken from the phase MSBs
    localparam int SND_W   = 16;

    // Clock enables that busy stays up after a data write
    localparam int BUSY_TICKS = 16;

    // Zero pulses per timer B count
    localparam int TMRB_PRESCALE = 16;

    typedef logic        [FNUM_W-1:0]  fnum_t;
    typedef logic        [BLOCK_W-1:0] block_t;
    typedef logic        [PHASE_W-1:0] phase_t;
    typedef logic signed [VOICE_W-1:0] voice_t;
    typedef logic signed [SND_W-1:0]   snd_t;

    // Register numbers seen through the two-step bus
    // Channel registers list the channel 0 number, the low two bits pick the channel
    typedef enum logic [7:0] {
        TIMER_A_HI = 8'h24,   // Timer A value bits 9:2
        TIMER_A_LO = 8'h25,   // Timer A value bits 1:0
        TIMER_B    = 8'h26,
        TIMER_CTL  = 8'h27,   // Load, irq enable and flag clear bits
        FNUM_LO    = 8'hA0,   // Low byte, commits the latched high part
        FNUM_HI    = 8'hA4,   // Block in 5:3, fnum 10:8 in 2:0
        PAN        = 8'hB4    // Left in bit 7, right in bit 6
    } reg_addr_e;

endpackage
